/* Bender.yml */
package:
  name: holy_core

export_include_dirs:
  - include

sources:
  - files:
      - source/holy_core_pkg.sv
      - source/control_if.sv
      - source/control.sv
      - source/alu.sv
      - source/regfile.sv
      - source/signext.sv
      - source/holy_core.sv
  - target: simulation
    files:
      - tb/holy_core_sva.sv
      - tb/holy_core_tb.sv

/* build.f */
+incdir+include
source/holy_core_pkg.sv
source/control_if.sv
source/control.sv
source/alu.sv
source/regfile.sv
source/signext.sv
source/holy_core.sv
tb/holy_core_sva.sv
tb/holy_core_tb.sv

/* include/holy_core_defines.svh */
`ifndef HOLY_CORE_DEFINES_SVH
`define HOLY_CORE_DEFINES_SVH

// Data and address width of the core
`define HC_XLEN 32

// Architectural registers, x0 included
`define HC_NUM_REGS 32

// First fetch address after reset
`define HC_RESET_PC 32'h0000_0000

`endif

/* source/alu.sv */
`include "holy_core_defines.svh"

module alu (
    input  holy_core_pkg::alu_ctrl_t alu_control,
    input  logic [`HC_XLEN-1:0]      src_a,
    input  logic [`HC_XLEN-1:0]      src_b,
    output logic [`HC_XLEN-1:0]      alu_result,
    output logic                     zero,
    output logic                     last_bit
);

    import holy_core_pkg::*;

    logic [4:0] shamt;
    logic       less_signed;
    logic       less_unsigned;

    // Shifts only look at the low five bits of operand B
    assign shamt = src_b[4:0];

    assign less_signed   = $signed(src_a) < $signed(src_b);
    assign less_unsigned = src_a < src_b;

    always_comb begin
        case (alu_control)
            ALU_ADD: begin
                alu_result = src_a + src_b;
            end
            ALU_SUB: begin
                alu_result = src_a - src_b;
            end
            ALU_AND: begin
                alu_result = src_a & src_b;
            end
            ALU_OR: begin
                alu_result = src_a | src_b;
            end
            ALU_XOR: begin
                alu_result = src_a ^ src_b;
            end
            ALU_SLT: begin
                alu_result = {{(`HC_XLEN-1){1'b0}}, less_signed};
            end
            ALU_SLTU: begin
                alu_result = {{(`HC_XLEN-1){1'b0}}, less_unsigned};
            end
            ALU_SLL: begin
                alu_result = src_a << shamt;
            end
            ALU_SRL: begin
                alu_result = src_a >> shamt;
            end
            ALU_SRA: begin
                alu_result = $signed(src_a) >>> shamt;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    // Flags used by the branch logic
    assign zero     = (alu_result == '0);
    assign last_bit = alu_result[0];

endmodule

/* source/control.sv */
module control (
    input  logic [6:0]       op,
    input  logic [2:0]       func3,
    input  logic [6:0]       func7,
    input  logic             alu_zero,
    input  logic             alu_last_bit,
    control_if.decoder       ctrl
);

    import holy_core_pkg::*;

    alu_op_t alu_op;
    logic    branch;
    logic    jump;
    logic    take_branch;

    // Main decoder
    always_comb begin
        // Idle values keep CPU and memory state untouched
        ctrl.reg_write         = 1'b0;
        ctrl.mem_write         = 1'b0;
        ctrl.imm_source        = IMM_I;
        ctrl.alu_source        = 1'b0;
        ctrl.write_back_source = WB_ALU;
        ctrl.second_add_source = ADD2_PC;
        alu_op                 = ALU_OP_LOAD_STORE;
        branch                 = 1'b0;
        jump                   = 1'b0;

        case (op)
            OPCODE_I_TYPE_LOAD: begin
                ctrl.reg_write         = 1'b1;
                ctrl.alu_source        = 1'b1;
                ctrl.write_back_source = WB_MEM;
            end
            OPCODE_I_TYPE_ALU: begin
                ctrl.alu_source = 1'b1;
                alu_op          = ALU_OP_MATH;
                // Shift immediates carry a func7 in the upper bits, only two are legal
                if (func3 == F3_SLL) begin
                    ctrl.reg_write = (func7 == F7_SLL_SRL);
                end else if (func3 == F3_SRL_SRA) begin
                    ctrl.reg_write = (func7 == F7_SLL_SRL) || (func7 == F7_SRA);
                end else begin
                    ctrl.reg_write = 1'b1;
                end
            end
            OPCODE_S_TYPE: begin
                ctrl.mem_write  = 1'b1;
                ctrl.imm_source = IMM_S;
                ctrl.alu_source = 1'b1;
            end
            OPCODE_R_TYPE: begin
                ctrl.reg_write = 1'b1;
                alu_op         = ALU_OP_MATH;
            end
            OPCODE_B_TYPE: begin
                ctrl.imm_source = IMM_B;
                alu_op          = ALU_OP_BRANCHES;
                branch          = 1'b1;
            end
            OPCODE_J_TYPE: begin
                ctrl.reg_write         = 1'b1;
                ctrl.imm_source        = IMM_J;
                ctrl.write_back_source = WB_PC4;
                jump                   = 1'b1;
            end
            OPCODE_J_TYPE_JALR: begin
                ctrl.reg_write         = 1'b1;
                ctrl.write_back_source = WB_PC4;
                ctrl.second_add_source = ADD2_RS1;
                jump                   = 1'b1;
            end
            OPCODE_U_TYPE_LUI: begin
                ctrl.reg_write         = 1'b1;
                ctrl.imm_source        = IMM_U;
                ctrl.write_back_source = WB_ADD2;
                ctrl.second_add_source = ADD2_ZERO;
            end
            OPCODE_U_TYPE_AUIPC: begin
                ctrl.reg_write         = 1'b1;
                ctrl.imm_source        = IMM_U;
                ctrl.write_back_source = WB_ADD2;
            end
            default: begin
                // Unknown opcode, pc just moves on
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        ctrl.alu_control = ALU_ADD;
        case (alu_op)
            ALU_OP_MATH: begin
                case (func3)
                    F3_ADD_SUB: begin
                        // Only the register form has a sub
                        if (op == OPCODE_R_TYPE && func7 == F7_SUB) begin
                            ctrl.alu_control = ALU_SUB;
                        end else begin
                            ctrl.alu_control = ALU_ADD;
                        end
                    end
                    F3_AND:  ctrl.alu_control = ALU_AND;
                    F3_OR:   ctrl.alu_control = ALU_OR;
                    F3_XOR:  ctrl.alu_control = ALU_XOR;
                    F3_SLT:  ctrl.alu_control = ALU_SLT;
                    F3_SLTU: ctrl.alu_control = ALU_SLTU;
                    F3_SLL:  ctrl.alu_control = ALU_SLL;
                    F3_SRL_SRA: begin
                        ctrl.alu_control = (func7 == F7_SRA) ? ALU_SRA : ALU_SRL;
                    end
                    default: ctrl.alu_control = ALU_ADD;
                endcase
            end
            ALU_OP_BRANCHES: begin
                // Compare flavour that sets the flag the branch looks at
                case (func3)
                    F3_BEQ, F3_BNE:   ctrl.alu_control = ALU_SUB;
                    F3_BLT, F3_BGE:   ctrl.alu_control = ALU_SLT;
                    F3_BLTU, F3_BGEU: ctrl.alu_control = ALU_SLTU;
                    default:          ctrl.alu_control = ALU_SUB;
                endcase
            end
            default: ctrl.alu_control = ALU_ADD;
        endcase
    end

    // Branch resolution from the ALU flags
    always_comb begin
        case (func3)
            F3_BEQ:           take_branch = branch & alu_zero;
            F3_BNE:           take_branch = branch & ~alu_zero;
            F3_BLT, F3_BLTU:  take_branch = branch & alu_last_bit;
            F3_BGE, F3_BGEU:  take_branch = branch & ~alu_last_bit;
            default:          take_branch = 1'b0;
        endcase
    end

    assign ctrl.pc_source = take_branch | jump;

endmodule

/* source/control_if.sv */
interface control_if;
    import holy_core_pkg::*;

    alu_ctrl_t alu_control;
    imm_src_t  imm_source;
    logic      mem_write;
    logic      reg_write;
    // High selects the immediate as ALU operand B
    logic      alu_source;
    wb_src_t   write_back_source;
    // High takes the second adder result as next pc
    logic      pc_source;
    add2_src_t second_add_source;

    modport decoder (
        output alu_control, imm_source, mem_write, reg_write,
        output alu_source, write_back_source, pc_source, second_add_source
    );

    modport datapath (
        input alu_control, imm_source, mem_write, reg_write,
        input alu_source, write_back_source, pc_source, second_add_source
    );

endinterface

/* source/holy_core.sv */
`include "holy_core_defines.svh"

module holy_core (
    input  logic                clk,
    input  logic                reset,

    // Instruction port
    output logic [`HC_XLEN-1:0] pc,
    input  logic [31:0]         instr,

    // Data port
    output logic [`HC_XLEN-1:0] data_addr,
    output logic [`HC_XLEN-1:0] data_wdata,
    output logic                data_we,
    input  logic [`HC_XLEN-1:0] data_rdata
);

    import holy_core_pkg::*;

    instr_u              instr_fields;
    logic [`HC_XLEN-1:0] pc_plus_4;
    logic [`HC_XLEN-1:0] pc_target;
    logic [`HC_XLEN-1:0] pc_next;
    logic [`HC_XLEN-1:0] add2_base;
    logic [`HC_XLEN-1:0] add2_result;
    logic [`HC_XLEN-1:0] immediate;
    logic [`HC_XLEN-1:0] read_data1;
    logic [`HC_XLEN-1:0] read_data2;
    logic [`HC_XLEN-1:0] alu_src_b;
    logic [`HC_XLEN-1:0] alu_result;
    logic [`HC_XLEN-1:0] write_back;
    logic                alu_zero;
    logic                alu_last_bit;
    logic                reg_write_en;

    control_if ctrl_bus ();

    assign instr_fields = instr;

    control u_control (
        .op           (instr_fields.r_fmt.opcode),
        .func3        (instr_fields.r_fmt.func3),
        .func7        (instr_fields.r_fmt.func7),
        .alu_zero     (alu_zero),
        .alu_last_bit (alu_last_bit),
        .ctrl         (ctrl_bus.decoder)
    );

    // No register or memory writes while in reset
    assign reg_write_en = ctrl_bus.reg_write & ~reset;
    assign data_we      = ctrl_bus.mem_write & ~reset;

    regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .read_addr1   (instr_fields.r_fmt.rs1),
        .read_addr2   (instr_fields.r_fmt.rs2),
        .write_addr   (instr_fields.r_fmt.rd),
        .write_data   (write_back),
        .write_enable (reg_write_en),
        .read_data1   (read_data1),
        .read_data2   (read_data2)
    );

    signext u_signext (
        .instr      (instr_fields),
        .imm_source (ctrl_bus.imm_source),
        .immediate  (immediate)
    );

    assign alu_src_b = ctrl_bus.alu_source ? immediate : read_data2;

    alu u_alu (
        .alu_control (ctrl_bus.alu_control),
        .src_a       (read_data1),
        .src_b       (alu_src_b),
        .alu_result  (alu_result),
        .zero        (alu_zero),
        .last_bit    (alu_last_bit)
    );

    // Second adder for branch, jump and upper immediate targets
    always_comb begin
        case (ctrl_bus.second_add_source)
            ADD2_PC:   add2_base = pc;
            ADD2_ZERO: add2_base = '0;
            ADD2_RS1:  add2_base = read_data1;
            default:   add2_base = pc;
        endcase
    end

    assign add2_result = add2_base + immediate;

    // jalr drops bit 0 of its target
    assign pc_target = (ctrl_bus.second_add_source == ADD2_RS1) ?
                       {add2_result[`HC_XLEN-1:1], 1'b0} : add2_result;

    assign pc_plus_4 = pc + `HC_XLEN'd4;
    assign pc_next   = ctrl_bus.pc_source ? pc_target : pc_plus_4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `HC_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (ctrl_bus.write_back_source)
            WB_ALU:  write_back = alu_result;
            WB_MEM:  write_back = data_rdata;
            WB_PC4:  write_back = pc_plus_4;
            WB_ADD2: write_back = add2_result;
            default: write_back = alu_result;
        endcase
    end

    // Word-only data accesses
    assign data_addr  = alu_result;
    assign data_wdata = read_data2;

endmodule

/* source/holy_core_pkg.sv */
package holy_core_pkg;

    // Major opcodes
    localparam logic [6:0] OPCODE_R_TYPE       = 7'b0110011;
    localparam logic [6:0] OPCODE_I_TYPE_ALU   = 7'b0010011;
    localparam logic [6:0] OPCODE_I_TYPE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_S_TYPE       = 7'b0100011;
    localparam logic [6:0] OPCODE_B_TYPE       = 7'b1100011;
    localparam logic [6:0] OPCODE_J_TYPE       = 7'b1101111;
    localparam logic [6:0] OPCODE_J_TYPE_JALR  = 7'b1100111;
    localparam logic [6:0] OPCODE_U_TYPE_LUI   = 7'b0110111;
    localparam logic [6:0] OPCODE_U_TYPE_AUIPC = 7'b0010111;

    // ALU func3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch func3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // func7 codes
    localparam logic [6:0] F7_SLL_SRL = 7'b0000000;
    localparam logic [6:0] F7_SRA     = 7'b0100000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_SLL  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SLTU = 4'b0111,
        ALU_XOR  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        ALU_OP_LOAD_STORE = 2'b00,
        ALU_OP_BRANCHES   = 2'b01,
        ALU_OP_MATH       = 2'b10
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_MEM  = 2'b01,
        WB_PC4  = 2'b10,
        WB_ADD2 = 2'b11
    } wb_src_t;

    // Base operand of the second adder
    typedef enum logic [1:0] {
        ADD2_PC   = 2'b00,
        ADD2_ZERO = 2'b01,
        ADD2_RS1  = 2'b10
    } add2_src_t;

    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, seen through every base format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

/* source/regfile.sv */
`include "holy_core_defines.svh"

module regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          read_addr1,
    input  logic [4:0]          read_addr2,
    input  logic [4:0]          write_addr,
    input  logic [`HC_XLEN-1:0] write_data,
    input  logic                write_enable,
    output logic [`HC_XLEN-1:0] read_data1,
    output logic [`HC_XLEN-1:0] read_data2
);

    // x0 has no storage
    logic [`HC_XLEN-1:0] regs [1:`HC_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `HC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data1 = (read_addr1 == 5'd0) ? '0 : regs[read_addr1];
    assign read_data2 = (read_addr2 == 5'd0) ? '0 : regs[read_addr2];

endmodule

/* source/signext.sv */
module signext (
    input  holy_core_pkg::instr_u   instr,
    input  holy_core_pkg::imm_src_t imm_source,
    output logic [31:0]             immediate
);

    import holy_core_pkg::*;

    logic sign;

    // Sign bit sits at bit 31 in every format
    assign sign = instr.r_fmt.func7[6];

    always_comb begin
        case (imm_source)
            IMM_I: begin
                immediate = {{20{sign}}, instr.i_fmt.imm_11_0};
            end
            IMM_S: begin
                immediate = {{20{sign}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
            end
            IMM_B: begin
                immediate = {{20{sign}},
                             instr.b_fmt.imm_11,
                             instr.b_fmt.imm_10_5,
                             instr.b_fmt.imm_4_1,
                             1'b0};
            end
            IMM_J: begin
                immediate = {{12{sign}},
                             instr.j_fmt.imm_19_12,
                             instr.j_fmt.imm_11,
                             instr.j_fmt.imm_10_1,
                             1'b0};
            end
            IMM_U: begin
                // Upper immediate, low bits zero filled
                immediate = {instr.u_fmt.imm_31_12, 12'b0};
            end
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

/* tb/holy_core_sva.sv */
`include "holy_core_defines.svh"

module holy_core_sva (
    input logic                clk,
    input logic                reset,
    input logic [`HC_XLEN-1:0] pc,
    input logic [31:0]         instr,
    input logic                data_we
);

    import holy_core_pkg::*;

    logic known_opcode;

    assign known_opcode = (instr[6:0] == OPCODE_R_TYPE)
                       || (instr[6:0] == OPCODE_I_TYPE_ALU)
                       || (instr[6:0] == OPCODE_I_TYPE_LOAD)
                       || (instr[6:0] == OPCODE_S_TYPE)
                       || (instr[6:0] == OPCODE_B_TYPE)
                       || (instr[6:0] == OPCODE_J_TYPE)
                       || (instr[6:0] == OPCODE_J_TYPE_JALR)
                       || (instr[6:0] == OPCODE_U_TYPE_LUI)
                       || (instr[6:0] == OPCODE_U_TYPE_AUIPC);

    // Memory stays untouched in reset
    no_store_in_reset: assert property (@(posedge clk) reset |-> !data_we)
        else $error("data_we high while reset is asserted");

    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // Unknown opcodes only step the pc
    unknown_op_steps_by_4: assert property (
        @(posedge clk) disable iff (reset) !known_opcode |=> pc == $past(pc) + 32'd4
    ) else $error("pc did not advance by 4 after an unknown opcode");

endmodule

bind holy_core holy_core_sva u_sva (
    .clk     (clk),
    .reset   (reset),
    .pc      (pc),
    .instr   (instr),
    .data_we (data_we)
);

/* tb/holy_core_tb.sv */
`include "holy_core_defines.svh"

module holy_core_tb;

    import holy_core_pkg::*;

    localparam int PROG_LEN    = 256;
    localparam int DMEM_WORDS  = 64;
    localparam int NUM_PROGS   = 4;
    localparam int RUN_CYCLES  = 2 * PROG_LEN;
    localparam int CYCLE_LIMIT = 4 * PROG_LEN * NUM_PROGS;
    localparam int DRIVE_DELAY = 1;

    logic                clk;
    logic                reset;
    logic [`HC_XLEN-1:0] pc;
    logic [31:0]         instr;
    logic [`HC_XLEN-1:0] data_addr;
    logic [`HC_XLEN-1:0] data_wdata;
    logic                data_we;
    logic [`HC_XLEN-1:0] data_rdata;

    logic [31:0]         imem [0:PROG_LEN-1];
    logic [31:0]         dmem [0:DMEM_WORDS-1];
    logic [31:0]         model_dmem [0:DMEM_WORDS-1];
    logic [31:0]         model_regs [0:31];
    logic [31:0]         model_pc;
    integer              seed;
    int                  cycle_count;

    holy_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Word-addressed memory models with combinational reads
    assign instr      = imem[pc[9:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    always @(posedge clk) begin
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped on timeout");
        end else begin
            cycle_count = cycle_count + 1;
        end
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failed check");
    endtask

    task automatic check_pc(input logic [`HC_XLEN-1:0] actual,
                            input logic [`HC_XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("mismatch pc: got %h, expected %h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_reg_value(input logic [`HC_XLEN-1:0] actual,
                                   input logic [`HC_XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("mismatch data_wdata (rs2 value): got %h, expected %h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_store(input logic [`HC_XLEN-1:0] addr,
                               input logic [`HC_XLEN-1:0] wdata,
                               input logic                we,
                               input logic [`HC_XLEN-1:0] exp_addr,
                               input logic [`HC_XLEN-1:0] exp_wdata,
                               input logic                exp_we);
        if (we !== exp_we) begin
            $display("mismatch data_we: got %h, expected %h", we, exp_we);
            abort_run();
        end else if (exp_we && addr !== exp_addr) begin
            $display("mismatch data_addr: got %h, expected %h", addr, exp_addr);
            abort_run();
        end else if (exp_we && wdata !== exp_wdata) begin
            $display("mismatch data_wdata: got %h, expected %h", wdata, exp_wdata);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [31:0] make_random_instr(input int slot);
        logic [31:0] r;
        logic [31:0] offset;
        logic [2:0]  f3;
        int          target;
        instr_u      ins;
        r   = next_random();
        ins = next_random();
        f3  = ins.r_fmt.func3;
        case (r[3:0])
            4'd0, 4'd1, 4'd2: begin
                ins.r_fmt.opcode = OPCODE_R_TYPE;
                ins.r_fmt.func7  = ((f3 == 3'b000 || f3 == 3'b101) && r[4]) ? 7'h20 : 7'h00;
            end
            4'd3, 4'd4, 4'd5: begin
                ins.i_fmt.opcode = OPCODE_I_TYPE_ALU;
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    ins.r_fmt.func7 = (f3 == 3'b101 && r[4]) ? 7'h20 : 7'h00;
                end
            end
            4'd6: begin
                // Shift immediate with a func7 that no shift uses
                ins.i_fmt.opcode = OPCODE_I_TYPE_ALU;
                ins.i_fmt.func3  = r[4] ? 3'b101 : 3'b001;
                ins.r_fmt.func7  = r[11:5] | 7'h01;
            end
            4'd7: ins.i_fmt.opcode = OPCODE_I_TYPE_LOAD;
            4'd8, 4'd9: ins.s_fmt.opcode = OPCODE_S_TYPE;
            4'd10: begin
                target = (slot + 1 + r[7:4]) % PROG_LEN;
                offset = (target - slot) * 4;
                ins.b_fmt.opcode = OPCODE_B_TYPE;
                ins.b_fmt.func3  = (f3[2:1] == 2'b01) ? {2'b00, f3[0]} : f3;
                {ins.b_fmt.imm_12, ins.b_fmt.imm_11, ins.b_fmt.imm_10_5,
                 ins.b_fmt.imm_4_1} = offset[12:1];
            end
            4'd11: begin
                target = (slot + 1 + r[9:4]) % PROG_LEN;
                offset = (target - slot) * 4;
                ins.j_fmt.opcode = OPCODE_J_TYPE;
                {ins.j_fmt.imm_20, ins.j_fmt.imm_19_12, ins.j_fmt.imm_11,
                 ins.j_fmt.imm_10_1} = offset[20:1];
            end
            4'd12: begin
                // Absolute target from x0 with bit 0 sometimes set
                ins.i_fmt.opcode   = OPCODE_J_TYPE_JALR;
                ins.i_fmt.func3    = 3'b000;
                ins.i_fmt.rs1      = 5'd0;
                ins.i_fmt.imm_11_0 = {2'b00, r[15:8], 1'b0, r[4]};
            end
            4'd13: ins.u_fmt.opcode = OPCODE_U_TYPE_LUI;
            4'd14: ins.u_fmt.opcode = OPCODE_U_TYPE_AUIPC;
            default: begin
                // custom-0, fence, system and custom-1 are not decoded
                case (r[5:4])
                    2'd0: ins.r_fmt.opcode = 7'b0001011;
                    2'd1: ins.r_fmt.opcode = 7'b0001111;
                    2'd2: ins.r_fmt.opcode = 7'b1110011;
                    default: ins.r_fmt.opcode = 7'b0101011;
                endcase
            end
        endcase
        return ins;
    endfunction

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = make_random_instr(i);
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]       = (i + 1) * 32'h9e37_79b9 ^ (i << 24);
            model_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        model_pc = `HC_RESET_PC;
    endtask

    function automatic logic [31:0] reference_alu(input logic [2:0] f3, input logic alt,
                                                  input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] a_signed;
        logic [31:0]        sra_val;
        logic [31:0]        res;
        a_signed = a;
        sra_val  = a_signed >>> b[4:0];
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: res = alt ? sra_val : a >> b[4:0];
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic shift_is_legal(input logic [31:0] w);
        if (w[14:12] == 3'b001) begin
            return w[31:25] == 7'h00;
        end
        if (w[14:12] == 3'b101) begin
            return (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
        end
        return 1'b1;
    endfunction

    // One ISA model step checked against the DUT before the edge
    task automatic step_model();
        logic [31:0] w;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] next_pc;
        logic [31:0] rd_val;
        logic [31:0] exp_addr;
        logic        rd_write;
        logic        exp_we;
        w        = imem[model_pc[9:2]];
        rs1_val  = model_regs[w[19:15]];
        rs2_val  = model_regs[w[24:20]];
        imm_i    = {{20{w[31]}}, w[31:20]};
        imm_s    = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        imm_u    = {w[31:12], 12'h000};
        next_pc  = model_pc + 32'd4;
        rd_val   = 32'h0;
        exp_addr = 32'h0;
        rd_write = 1'b0;
        exp_we   = 1'b0;
        check_pc(pc, model_pc);
        check_reg_value(data_wdata, rs2_val);
        case (w[6:0])
            OPCODE_R_TYPE: begin
                rd_write = 1'b1;
                rd_val   = reference_alu(w[14:12], w[30], rs1_val, rs2_val);
            end
            OPCODE_I_TYPE_ALU: begin
                rd_write = shift_is_legal(w);
                rd_val   = reference_alu(w[14:12], (w[14:12] == 3'b101) && w[30],
                                         rs1_val, imm_i);
            end
            OPCODE_I_TYPE_LOAD: begin
                rd_write = 1'b1;
                exp_addr = rs1_val + imm_i;
                rd_val   = model_dmem[exp_addr[7:2]];
            end
            OPCODE_S_TYPE: begin
                exp_we   = 1'b1;
                exp_addr = rs1_val + imm_s;
            end
            OPCODE_B_TYPE: begin
                if (branch_taken(w[14:12], rs1_val, rs2_val)) begin
                    next_pc = model_pc + imm_b;
                end
            end
            OPCODE_J_TYPE: begin
                rd_write = 1'b1;
                rd_val   = model_pc + 32'd4;
                next_pc  = model_pc + imm_j;
            end
            OPCODE_J_TYPE_JALR: begin
                rd_write = 1'b1;
                rd_val   = model_pc + 32'd4;
                next_pc  = (rs1_val + imm_i) & ~32'd1;
            end
            OPCODE_U_TYPE_LUI: begin
                rd_write = 1'b1;
                rd_val   = imm_u;
            end
            OPCODE_U_TYPE_AUIPC: begin
                rd_write = 1'b1;
                rd_val   = model_pc + imm_u;
            end
            default: begin
                // Not an RV32I subset opcode so only the pc moves
            end
        endcase
        check_store(data_addr, data_wdata, data_we, exp_addr, rs2_val, exp_we);
        if (rd_write && w[11:7] != 5'd0) begin
            model_regs[w[11:7]] = rd_val;
        end
        if (exp_we) begin
            model_dmem[exp_addr[7:2]] = rs2_val;
        end
        model_pc = next_pc;
    endtask

    initial begin
        seed        = 32'hf440f2b6;
        reset       = 1'b1;
        cycle_count = 0;
        for (int prog = 0; prog < NUM_PROGS; prog++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            reset = 1'b1;
            load_program();
            // Four edges with reset high while pc holds and nothing is stored
            repeat (3) begin
                @(posedge clk);
                @(negedge clk);
                check_pc(pc, `HC_RESET_PC);
                check_store(data_addr, data_wdata, data_we, 32'h0, 32'h0, 1'b0);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            reset = 1'b0;
            for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
                @(negedge clk);
                step_model();
                @(posedge clk);
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
